// File: axil_sdram_vectors.txt
# op byte_addr wdata wstrb exp_rdata exp_resp (all hex)
# exp_rdata is ignored for W lines; resp 0 is OKAY, 2 is SLVERR
W 00000000 11223344 F 00000000 0
R 00000000 00000000 0 11223344 0
W 00000010 AABBCCDD F 00000000 0
W 00000010 55667788 5 00000000 0
R 00000010 00000000 0 AA66CC88 0
W 00000020 DEADBEEF 2 00000000 0
R 00000020 00000000 0 0000BE00 0
W 00000400 B1B2B3B4 F 00000000 0
W 00001000 C1C2C3C4 F 00000000 0
W 01FFFFFC D1D2D3D4 F 00000000 0
R 00000400 00000000 0 B1B2B3B4 0
R 00001000 00000000 0 C1C2C3C4 0
R 01FFFFFC 00000000 0 D1D2D3D4 0
W 02000000 FFFFFFFF F 00000000 2
R 02000000 00000000 0 00000000 2
R 00000000 00000000 0 11223344 0

// File: compile.f
sdram_pkg.sv
sdram_host_if.sv
axil_sdram_bridge.sv
sdram_controller.sv
axil_sdram_top.sv
sdram_model.sv
axil_sdram_checker.sv
axil_sdram_asserts.sv
tb_axil_sdram.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timing --top-module tb_axil_sdram -f compile.f
status=0
./obj_dir/Vtb_axil_sdram > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// File: tb_axil_sdram.sv
`timescale 1ns/100ps

module tb_axil_sdram;

    localparam int INIT_CYCLES    = 200;
    localparam int REFRESH_CYCLES = 400;
    // Replaying the list keeps the expected data valid and spans several refreshes
    localparam int PASSES         = 4;

    logic        aclk;
    logic        aresetn;
    logic [31:0] s_axil_awaddr;
    logic        s_axil_awvalid;
    logic        s_axil_awready;
    logic [31:0] s_axil_wdata;
    logic [3:0]  s_axil_wstrb;
    logic        s_axil_wvalid;
    logic        s_axil_wready;
    logic [1:0]  s_axil_bresp;
    logic        s_axil_bvalid;
    logic        s_axil_bready;
    logic [31:0] s_axil_araddr;
    logic        s_axil_arvalid;
    logic        s_axil_arready;
    logic [31:0] s_axil_rdata;
    logic [1:0]  s_axil_rresp;
    logic        s_axil_rvalid;
    logic        s_axil_rready;

    logic        sdram_cke;
    logic        sdram_csn;
    logic        sdram_rasn;
    logic        sdram_casn;
    logic        sdram_wen;
    logic [12:0] sdram_a;
    logic [1:0]  sdram_ba;
    logic [1:0]  sdram_dqm;
    logic [15:0] sdram_dq_out;
    logic        sdram_dq_oe;
    logic [15:0] sdram_dq_in;

    logic [7:0]  op_q [$];
    logic [31:0] addr_q [$];
    logic [31:0] wdata_q [$];
    logic [3:0]  strb_q [$];

    int          seed = 32'h67707796;
    logic [31:0] rnd;
    int          cycles;
    int          cycle_limit;
    int          total;
    int          other_errors;
    int          chk_errors;
    int          chk_count;

    axil_sdram_top #(
        .INIT_CYCLES    (INIT_CYCLES),
        .REFRESH_CYCLES (REFRESH_CYCLES)
    ) dut (
        .*
    );

    sdram_model u_model (
        .aclk    (aclk),
        .aresetn (aresetn),
        .cke     (sdram_cke),
        .csn     (sdram_csn),
        .rasn    (sdram_rasn),
        .casn    (sdram_casn),
        .wen     (sdram_wen),
        .a       (sdram_a),
        .ba      (sdram_ba),
        .dqm     (sdram_dqm),
        .dq_wr   (sdram_dq_out),
        .dq_oe   (sdram_dq_oe),
        .dq_rd   (sdram_dq_in)
    );

    axil_sdram_checker u_checker (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .bresp       (s_axil_bresp),
        .bvalid      (s_axil_bvalid),
        .bready      (s_axil_bready),
        .rdata       (s_axil_rdata),
        .rresp       (s_axil_rresp),
        .rvalid      (s_axil_rvalid),
        .rready      (s_axil_rready),
        .error_count (chk_errors),
        .check_count (chk_count)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #4 aclk = ~aclk;
        end
    end

    // Random back-pressure on B and R
    initial begin
        s_axil_bready = 1'b0;
        s_axil_rready = 1'b0;
        forever begin
            @(posedge aclk);
            #1;
            rnd = $random(seed);
            s_axil_bready = rnd[0];
            s_axil_rready = rnd[1];
        end
    end

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [31:0] exp_rdata;
        logic [1:0]  exp_resp;
        fd = $fopen("axil_sdram_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open axil_sdram_vectors.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ((line.len() > 0) && (line.getc(0) != "#")) begin
                n = $sscanf(line, "%c %h %h %h %h %h", op, addr, wdata, strb,
                            exp_rdata, exp_resp);
                if (n == 6) begin
                    op_q.push_back(op);
                    addr_q.push_back(addr);
                    wdata_q.push_back(wdata);
                    strb_q.push_back(strb);
                end
            end
        end
        $fclose(fd);
    endtask

    // Handshakes are sampled on the falling edge, where everything is settled
    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_wstrb   = strb;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        @(negedge aclk);
        while (!(s_axil_awready || s_axil_wready)) begin
            @(negedge aclk);
        end
        if (s_axil_awready != s_axil_wready) begin
            $display("Write address and write data were not accepted together at %0t",
                     $time);
            other_errors++;
        end
        @(posedge aclk);
        #1;
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
    endtask

    task automatic read_word(input logic [31:0] addr);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        @(negedge aclk);
        while (!s_axil_arready) begin
            @(negedge aclk);
        end
        @(posedge aclk);
        #1;
        s_axil_arvalid = 1'b0;
    endtask

    task automatic print_counts();
        $display("Responses checked: %0d, mismatches: %0d, other errors: %0d",
                 chk_count, chk_errors, other_errors);
    endtask

    initial begin
        cycles = 0;
        @(posedge aclk);
        while ((cycle_limit == 0) || (cycles < cycle_limit)) begin
            @(posedge aclk);
            cycles++;
        end
        $display("Run timed out after %0d cycles", cycles);
        other_errors++;
        print_counts();
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        aresetn        = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        other_errors   = 0;
        cycle_limit    = 0;
        load_vectors();
        if (op_q.size() == 0) begin
            $display("No transactions were read from the vector file");
            other_errors++;
        end
        total       = op_q.size() * PASSES;
        cycle_limit = 400 + INIT_CYCLES + total * 64;
        repeat (16) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        // Next request waits with valid high while the previous response is pending
        for (int p = 0; p < PASSES; p++) begin
            for (int i = 0; i < op_q.size(); i++) begin
                if (op_q[i] == "W") begin
                    write_word(addr_q[i], wdata_q[i], strb_q[i]);
                end else begin
                    read_word(addr_q[i]);
                end
            end
        end
        while (chk_count < total) begin
            @(posedge aclk);
        end
        repeat (4) @(posedge aclk);
        if (chk_count != total) begin
            $display("Checker saw %0d responses but %0d were issued", chk_count, total);
            other_errors++;
        end
        print_counts();
        if ((chk_errors == 0) && (other_errors == 0)) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: axil_sdram_asserts.sv
`timescale 1ns/100ps

module axil_sdram_asserts
    import sdram_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        s_axil_awready,
    input  logic        s_axil_arready,
    input  logic [1:0]  s_axil_bresp,
    input  logic        s_axil_bvalid,
    input  logic        s_axil_bready,
    input  logic [31:0] s_axil_rdata,
    input  logic [1:0]  s_axil_rresp,
    input  logic        s_axil_rvalid,
    input  logic        s_axil_rready,
    input  logic        sdram_cke,
    input  logic        sdram_csn,
    input  logic        sdram_rasn,
    input  logic        sdram_casn,
    input  logic        sdram_wen
);

    logic [3:0] cmd;

    assign cmd = {sdram_csn, sdram_rasn, sdram_casn, sdram_wen};

    b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp))
        else $error("bvalid dropped or bresp changed before bready");

    r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_rvalid && !s_axil_rready |=>
            s_axil_rvalid && $stable(s_axil_rdata) && $stable(s_axil_rresp))
        else $error("rvalid dropped or read data changed before rready");

    // Column commands need the clock enabled
    rw_cke: assert property (@(posedge aclk) disable iff (!aresetn)
        (cmd == CMD_READ) || (cmd == CMD_WRITE) |-> sdram_cke)
        else $error("READ or WRITE issued while cke is low");

    one_in_flight: assert property (@(posedge aclk) disable iff (!aresetn)
        s_axil_bvalid || s_axil_rvalid |-> !(s_axil_awready || s_axil_arready))
        else $error("New address accepted while a response is pending");

endmodule

bind axil_sdram_top axil_sdram_asserts u_asserts (.*);

// File: axil_sdram_checker.sv
`timescale 1ns/100ps

module axil_sdram_checker
    import sdram_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,
    input  logic [1:0]  bresp,
    input  logic        bvalid,
    input  logic        bready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rvalid,
    input  logic        rready,
    output int          error_count,
    output int          check_count
);

    logic [7:0]  exp_op [$];
    logic [31:0] exp_rdata [$];
    logic [1:0]  exp_resp [$];
    int          errors;
    int          checks;
    int          idx;

    assign error_count = errors;
    assign check_count = checks;

    initial begin : read_expected
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [31:0] vec_rdata;
        logic [1:0]  resp;
        errors = 0;
        checks = 0;
        idx    = 0;
        fd = $fopen("axil_sdram_vectors.txt", "r");
        if (fd == 0) begin
            $display("Checker could not open axil_sdram_vectors.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if ((line.len() > 0) && (line.getc(0) != "#")) begin
                    n = $sscanf(line, "%c %h %h %h %h %h", op, addr, wdata, strb, vec_rdata, resp);
                    if (n == 6) begin
                        if ((resp != AXI_RESP_OKAY) && (resp != AXI_RESP_SLVERR)) begin
                            $display("Vector file holds an unknown response code %0h", resp);
                            errors++;
                        end
                        exp_op.push_back(op);
                        exp_rdata.push_back(vec_rdata);
                        exp_resp.push_back(resp);
                    end
                end
            end
            $fclose(fd);
        end
    end

    // Vectors repeat, so the index wraps around the list
    always @(posedge aclk) begin
        if (aresetn && bvalid && bready) begin
            if ((exp_op.size() == 0) || (exp_op[idx] != "W")) begin
                $display("A write response arrived where no write was expected");
                errors++;
            end else if (bresp != exp_resp[idx]) begin
                $display("Error at %0d ns: s_axil_bresp expected %0h, got %0h",
                         $time, exp_resp[idx], bresp);
                errors++;
            end
            checks++;
            idx = (exp_op.size() == 0) ? 0 : (idx + 1) % exp_op.size();
        end
        if (aresetn && rvalid && rready) begin
            if ((exp_op.size() == 0) || (exp_op[idx] != "R")) begin
                $display("A read response arrived where no read was expected");
                errors++;
            end else begin
                if (rresp != exp_resp[idx]) begin
                    $display("Error at %0d ns: s_axil_rresp expected %0h, got %0h",
                             $time, exp_resp[idx], rresp);
                    errors++;
                end
                if (rdata != exp_rdata[idx]) begin
                    $display("Error at %0d ns: s_axil_rdata expected %h, got %h",
                             $time, exp_rdata[idx], rdata);
                    errors++;
                end
            end
            checks++;
            idx = (exp_op.size() == 0) ? 0 : (idx + 1) % exp_op.size();
        end
    end

endmodule

// File: sdram_model.sv
`timescale 1ns/100ps

module sdram_model
    import sdram_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        cke,
    input  logic        csn,
    input  logic        rasn,
    input  logic        casn,
    input  logic        wen,
    input  logic [12:0] a,
    input  logic [1:0]  ba,
    input  logic [1:0]  dqm,
    input  logic [15:0] dq_wr,
    input  logic        dq_oe,
    output logic [15:0] dq_rd
);

    localparam int unsigned DEPTH = SDRAM_BYTES / 2;

    // Sparse storage, unwritten half-words read as zero
    logic [15:0]  mem [int unsigned];
    logic [12:0]  open_row [4];
    logic [15:0]  rd_pipe;
    logic [15:0]  half;
    logic [3:0]   cmd;
    int unsigned  idx;

    assign cmd = {csn, rasn, casn, wen};
    assign idx = 32'({open_row[ba], ba, a[8:0]}) % DEPTH;

    always @(posedge aclk) begin
        if (!aresetn) begin
            rd_pipe <= '0;
            dq_rd   <= '0;
        end else begin
            // Second stage of the CAS latency 2 pipe
            dq_rd <= rd_pipe;
            if (cke) begin
                if (cmd == CMD_ACTIVE) begin
                    open_row[ba] = a;
                end
                if ((cmd == CMD_WRITE) && dq_oe) begin
                    half = mem.exists(idx) ? mem[idx] : 16'h0000;
                    if (!dqm[0]) begin
                        half[7:0] = dq_wr[7:0];
                    end
                    if (!dqm[1]) begin
                        half[15:8] = dq_wr[15:8];
                    end
                    mem[idx] = half;
                end
                if (cmd == CMD_READ) begin
                    rd_pipe <= mem.exists(idx) ? mem[idx] : 16'h0000;
                end
            end
        end
    end

endmodule

// File: axil_sdram_top.sv
`timescale 1ns/100ps

module axil_sdram_top #(
    parameter int INIT_CYCLES    = 13300,
    parameter int REFRESH_CYCLES = 1040
) (
    input  logic        aclk,
    input  logic        aresetn,

    input  logic [31:0] s_axil_awaddr,
    input  logic        s_axil_awvalid,
    output logic        s_axil_awready,
    input  logic [31:0] s_axil_wdata,
    input  logic [3:0]  s_axil_wstrb,
    input  logic        s_axil_wvalid,
    output logic        s_axil_wready,
    output logic [1:0]  s_axil_bresp,
    output logic        s_axil_bvalid,
    input  logic        s_axil_bready,
    input  logic [31:0] s_axil_araddr,
    input  logic        s_axil_arvalid,
    output logic        s_axil_arready,
    output logic [31:0] s_axil_rdata,
    output logic [1:0]  s_axil_rresp,
    output logic        s_axil_rvalid,
    input  logic        s_axil_rready,

    output logic        sdram_cke,
    output logic        sdram_csn,
    output logic        sdram_rasn,
    output logic        sdram_casn,
    output logic        sdram_wen,
    output logic [12:0] sdram_a,
    output logic [1:0]  sdram_ba,
    output logic [1:0]  sdram_dqm,
    output logic [15:0] sdram_dq_out,
    output logic        sdram_dq_oe,
    input  logic [15:0] sdram_dq_in
);

    sdram_host_if host ();

    axil_sdram_bridge u_bridge (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .host           (host.bridge)
    );

    sdram_controller #(
        .INIT_CYCLES    (INIT_CYCLES),
        .REFRESH_CYCLES (REFRESH_CYCLES)
    ) u_ctrl (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .host         (host.ctrl),
        .sdram_cke    (sdram_cke),
        .sdram_csn    (sdram_csn),
        .sdram_rasn   (sdram_rasn),
        .sdram_casn   (sdram_casn),
        .sdram_wen    (sdram_wen),
        .sdram_a      (sdram_a),
        .sdram_ba     (sdram_ba),
        .sdram_dqm    (sdram_dqm),
        .sdram_dq_out (sdram_dq_out),
        .sdram_dq_oe  (sdram_dq_oe),
        .sdram_dq_in  (sdram_dq_in)
    );

endmodule

// File: sdram_controller.sv
`timescale 1ns/100ps

module sdram_controller
    import sdram_pkg::*;
#(
    parameter int INIT_CYCLES    = 13300,
    parameter int REFRESH_CYCLES = 1040
) (
    input  logic        aclk,
    input  logic        aresetn,

    sdram_host_if.ctrl  host,

    output logic        sdram_cke,
    output logic        sdram_csn,
    output logic        sdram_rasn,
    output logic        sdram_casn,
    output logic        sdram_wen,
    output logic [12:0] sdram_a,
    output logic [1:0]  sdram_ba,
    output logic [1:0]  sdram_dqm,
    output logic [15:0] sdram_dq_out,
    output logic        sdram_dq_oe,
    input  logic [15:0] sdram_dq_in
);

    localparam int CNT_W = $clog2(INIT_CYCLES + 24);
    localparam int REF_W = $clog2(REFRESH_CYCLES);

    // Init schedule relative to the end of the power-up wait
    localparam logic [CNT_W-1:0] T_CKE  = CNT_W'(INIT_CYCLES - 1);
    localparam logic [CNT_W-1:0] T_PRE  = CNT_W'(INIT_CYCLES);
    localparam logic [CNT_W-1:0] T_REF1 = CNT_W'(INIT_CYCLES + 2);
    localparam logic [CNT_W-1:0] T_REF2 = CNT_W'(INIT_CYCLES + 10);
    localparam logic [CNT_W-1:0] T_MODE = CNT_W'(INIT_CYCLES + 18);
    localparam logic [CNT_W-1:0] T_DONE = CNT_W'(INIT_CYCLES + 21);

    // Refresh recovery and access steps
    localparam logic [CNT_W-1:0] T_RFC    = CNT_W'(7);
    localparam logic [CNT_W-1:0] T_RW     = CNT_W'(1);
    localparam logic [CNT_W-1:0] T_SAMPLE = CNT_W'(4);
    localparam logic [CNT_W-1:0] T_END    = CNT_W'(5);

    localparam logic [REF_W-1:0] REF_LAST = REF_W'(REFRESH_CYCLES - 1);

    // CAS latency 2, sequential, burst length 1
    localparam logic [12:0] MODE_REG = 13'b000_0_00_010_0_000;

    localparam logic [1:0] ST_INIT    = 2'd0;
    localparam logic [1:0] ST_IDLE    = 2'd1;
    localparam logic [1:0] ST_REFRESH = 2'd2;
    localparam logic [1:0] ST_ACCESS  = 2'd3;

    logic [1:0]       state;
    logic [CNT_W-1:0] cnt;
    logic [REF_W-1:0] ref_cnt;
    logic             ref_pending;
    logic             req_pend;
    sdram_cmd_t       cmd;
    logic             host_req;
    logic             issue_act;
    logic             issue_rw;
    sdram_addr_u      act_addr;
    sdram_addr_u      req_addr;
    logic             req_wr;
    logic [15:0]      req_data;
    logic [1:0]       req_mask;

    assign {sdram_csn, sdram_rasn, sdram_casn, sdram_wen} = cmd;

    assign host_req  = !host.busy && (host.wr_enable || host.rd_enable);
    // ACTIVE straight from idle, or after a refresh that delayed a request
    assign issue_act = ((state == ST_IDLE) && !ref_pending && host_req) ||
                       ((state == ST_REFRESH) && (cnt == T_RFC) && req_pend);
    assign issue_rw  = (state == ST_ACCESS) && (cnt == T_RW);
    assign act_addr  = (state == ST_IDLE) ? host.addr : req_addr;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state       <= ST_INIT;
            cnt         <= '0;
            ref_cnt     <= '0;
            ref_pending <= 1'b0;
            req_pend    <= 1'b0;
            cmd         <= CMD_NOP;
            sdram_cke   <= 1'b0;
            sdram_dq_oe <= 1'b0;
            host.busy   <= 1'b1;
            host.rd_ready <= 1'b0;
        end else begin
            cmd           <= CMD_NOP;
            sdram_dq_oe   <= 1'b0;
            host.rd_ready <= 1'b0;

            case (state)
                ST_INIT: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == T_CKE) begin
                        sdram_cke <= 1'b1;
                    end
                    if (cnt == T_PRE) begin
                        cmd <= CMD_PRECHARGE;
                    end
                    if ((cnt == T_REF1) || (cnt == T_REF2)) begin
                        cmd <= CMD_REFRESH;
                    end
                    if (cnt == T_MODE) begin
                        cmd <= CMD_LOAD_MODE;
                    end
                    if (cnt == T_DONE) begin
                        cnt       <= '0;
                        state     <= ST_IDLE;
                        host.busy <= 1'b0;
                    end
                end
                ST_IDLE: begin
                    cnt <= '0;
                    // Refresh goes first, a strobe in the same cycle waits for it
                    if (ref_pending) begin
                        cmd         <= CMD_REFRESH;
                        ref_pending <= 1'b0;
                        req_pend    <= host_req;
                        host.busy   <= 1'b1;
                        state       <= ST_REFRESH;
                    end else if (host_req) begin
                        cmd       <= CMD_ACTIVE;
                        host.busy <= 1'b1;
                        state     <= ST_ACCESS;
                    end
                end
                ST_REFRESH: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == T_RFC) begin
                        cnt <= '0;
                        if (req_pend) begin
                            cmd      <= CMD_ACTIVE;
                            req_pend <= 1'b0;
                            state    <= ST_ACCESS;
                        end else begin
                            host.busy <= 1'b0;
                            state     <= ST_IDLE;
                        end
                    end
                end
                default: begin
                    cnt <= cnt + 1'b1;
                    // tRCD of two cycles after ACTIVE
                    if (issue_rw) begin
                        cmd         <= req_wr ? CMD_WRITE : CMD_READ;
                        sdram_dq_oe <= req_wr;
                    end
                    if ((cnt == T_SAMPLE) && !req_wr) begin
                        host.rd_ready <= 1'b1;
                    end
                    // Auto-precharge recovery is covered by the remaining steps
                    if (cnt == T_END) begin
                        cnt       <= '0;
                        host.busy <= 1'b0;
                        state     <= ST_IDLE;
                    end
                end
            endcase

            if (state != ST_INIT) begin
                if (ref_cnt == REF_LAST) begin
                    ref_cnt     <= '0;
                    ref_pending <= 1'b1;
                end else begin
                    ref_cnt <= ref_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if ((state == ST_IDLE) && host_req) begin
            req_addr <= host.addr;
            req_wr   <= host.wr_enable;
            req_data <= host.wr_data;
            req_mask <= host.wr_mask;
        end
        if ((state == ST_INIT) && (cnt == T_PRE)) begin
            // A10 high selects all banks
            sdram_a   <= 13'h0400;
            sdram_dqm <= 2'b11;
        end
        if ((state == ST_INIT) && (cnt == T_MODE)) begin
            sdram_a  <= MODE_REG;
            sdram_ba <= 2'b00;
        end
        if (issue_act) begin
            sdram_a  <= act_addr.fields.row;
            sdram_ba <= act_addr.fields.bank;
        end
        if (issue_rw) begin
            // A10 set for auto-precharge
            sdram_a      <= {2'b00, 1'b1, 1'b0, req_addr.fields.col};
            sdram_dqm    <= req_wr ? req_mask : 2'b00;
            sdram_dq_out <= req_data;
        end
        // Data valid two edges after the READ edge
        if ((state == ST_ACCESS) && (cnt == T_SAMPLE)) begin
            host.rd_data <= sdram_dq_in;
        end
    end

endmodule

// File: axil_sdram_bridge.sv
`timescale 1ns/100ps

module axil_sdram_bridge
    import sdram_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,

    input  logic [31:0] s_axil_awaddr,
    input  logic        s_axil_awvalid,
    output logic        s_axil_awready,
    input  logic [31:0] s_axil_wdata,
    input  logic [3:0]  s_axil_wstrb,
    input  logic        s_axil_wvalid,
    output logic        s_axil_wready,
    output logic [1:0]  s_axil_bresp,
    output logic        s_axil_bvalid,
    input  logic        s_axil_bready,
    input  logic [31:0] s_axil_araddr,
    input  logic        s_axil_arvalid,
    output logic        s_axil_arready,
    output logic [31:0] s_axil_rdata,
    output logic [1:0]  s_axil_rresp,
    output logic        s_axil_rvalid,
    input  logic        s_axil_rready,

    sdram_host_if.bridge host
);

    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_WR_LO = 3'd1;
    localparam logic [2:0] ST_WR_HI = 3'd2;
    localparam logic [2:0] ST_RD_LO = 3'd3;
    localparam logic [2:0] ST_RD_HI = 3'd4;
    localparam logic [2:0] ST_RESP  = 3'd5;

    logic [2:0]  state;
    logic        issued;
    logic [22:0] word_addr;
    logic [31:0] wdata_q;
    logic [3:0]  wstrb_q;
    logic        aw_take;
    logic        ar_take;
    logic        aw_oor;
    logic        ar_oor;
    logic        wr_phase;
    logic        rd_phase;
    logic        hi_half;
    logic        half_done;
    sdram_addr_u host_addr;

    // Write pair wins over a read in the same cycle
    assign aw_take = (state == ST_IDLE) && s_axil_awvalid && s_axil_wvalid;
    assign ar_take = (state == ST_IDLE) && s_axil_arvalid && !(s_axil_awvalid && s_axil_wvalid);

    assign s_axil_awready = aw_take;
    assign s_axil_wready  = aw_take;
    assign s_axil_arready = ar_take;

    assign aw_oor = s_axil_awaddr >= SDRAM_BYTES;
    assign ar_oor = s_axil_araddr >= SDRAM_BYTES;

    assign wr_phase  = (state == ST_WR_LO) || (state == ST_WR_HI);
    assign rd_phase  = (state == ST_RD_LO) || (state == ST_RD_HI);
    assign hi_half   = (state == ST_WR_HI) || (state == ST_RD_HI);
    // Half is finished once busy drops after our strobe
    assign half_done = issued && !host.busy;

    assign host_addr.flat = {word_addr, hi_half};
    assign host.addr      = host_addr;
    assign host.wr_data   = hi_half ? wdata_q[31:16] : wdata_q[15:0];
    assign host.wr_mask   = hi_half ? ~wstrb_q[3:2] : ~wstrb_q[1:0];
    assign host.wr_enable = wr_phase && !issued && !host.busy;
    assign host.rd_enable = rd_phase && !issued && !host.busy;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state         <= ST_IDLE;
            issued        <= 1'b0;
            s_axil_bvalid <= 1'b0;
            s_axil_rvalid <= 1'b0;
        end else begin
            if (host.wr_enable || host.rd_enable) begin
                issued <= 1'b1;
            end else if (half_done) begin
                issued <= 1'b0;
            end

            case (state)
                ST_IDLE: begin
                    if (aw_take) begin
                        // Out of range answers at once, no SDRAM access
                        if (aw_oor) begin
                            s_axil_bvalid <= 1'b1;
                            state         <= ST_RESP;
                        end else begin
                            state <= ST_WR_LO;
                        end
                    end else if (ar_take) begin
                        if (ar_oor) begin
                            s_axil_rvalid <= 1'b1;
                            state         <= ST_RESP;
                        end else begin
                            state <= ST_RD_LO;
                        end
                    end
                end
                ST_WR_LO: begin
                    if (half_done) begin
                        state <= ST_WR_HI;
                    end
                end
                ST_WR_HI: begin
                    if (half_done) begin
                        s_axil_bvalid <= 1'b1;
                        state         <= ST_RESP;
                    end
                end
                ST_RD_LO: begin
                    if (half_done) begin
                        state <= ST_RD_HI;
                    end
                end
                ST_RD_HI: begin
                    if (half_done) begin
                        s_axil_rvalid <= 1'b1;
                        state         <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    // Hold here under back-pressure
                    if ((s_axil_bvalid && s_axil_bready) || (s_axil_rvalid && s_axil_rready)) begin
                        s_axil_bvalid <= 1'b0;
                        s_axil_rvalid <= 1'b0;
                        state         <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (aw_take) begin
            word_addr    <= s_axil_awaddr[24:2];
            wdata_q      <= s_axil_wdata;
            wstrb_q      <= s_axil_wstrb;
            s_axil_bresp <= aw_oor ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
        end
        if (ar_take) begin
            word_addr    <= s_axil_araddr[24:2];
            s_axil_rdata <= '0;
            s_axil_rresp <= ar_oor ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
        end
        // Low half arrives first, then high half
        if (host.rd_ready && (state == ST_RD_LO)) begin
            s_axil_rdata[15:0] <= host.rd_data;
        end
        if (host.rd_ready && (state == ST_RD_HI)) begin
            s_axil_rdata[31:16] <= host.rd_data;
        end
    end

endmodule

// File: sdram_host_if.sv
`timescale 1ns/100ps

interface sdram_host_if import sdram_pkg::*; ();

    sdram_addr_u addr;
    logic [15:0] wr_data;
    // High bit masks the byte, as on DQM
    logic [1:0]  wr_mask;
    logic        wr_enable;
    logic        rd_enable;
    logic        busy;
    logic [15:0] rd_data;
    logic        rd_ready;

    modport bridge (
        output addr, wr_data, wr_mask, wr_enable, rd_enable,
        input  busy, rd_data, rd_ready
    );

    modport ctrl (
        input  addr, wr_data, wr_mask, wr_enable, rd_enable,
        output busy, rd_data, rd_ready
    );

endinterface

// File: sdram_pkg.sv
package sdram_pkg;

    // Half-word address into the 16-bit device
    typedef logic [23:0] sdram_word_addr_t;

    // Same 24 bits seen flat by the bridge and as row/bank/column by the controller
    typedef union packed {
        sdram_word_addr_t flat;
        struct packed {
            logic [12:0] row;
            logic [1:0]  bank;
            logic [8:0]  col;
        } fields;
    } sdram_addr_u;

    // {csn, rasn, casn, wen}
    typedef enum logic [3:0] {
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010,
        CMD_REFRESH   = 4'b0001,
        CMD_LOAD_MODE = 4'b0000
    } sdram_cmd_t;

    localparam logic [31:0] SDRAM_BYTES = 32'h0200_0000;

    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage
